/* mem_pkg.sv */
/*
  Memory subsystem sizing package.
  Bus and RAM widths, bank count and the word address split used by
  the Wishbone bank decoder and the per-bank port adapters.
*/

package mem_pkg;

  ////////////////////////////////////////
  // data path
  ////////////////////////////////////////

  localparam int wb_dw = 32;       // bus and ram data width
  localparam int sel_w = wb_dw/8;  // byte lanes, one sel bit each

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // word address inside one bank
  localparam int mem_aw = 10;      // 1024 words per bank

  localparam int n_banks    = 2;
  localparam int bank_sel_w = $clog2(n_banks);  // bank index bits above mem_aw

  // master word address
  //   [mem_aw-1:0]  word within bank
  //   [mem_aw]      bank select
  //   [wb_aw-1]     set -> out of range, answered with err
  localparam int wb_aw = mem_aw + bank_sel_w + 1;  // 12
  localparam int range_bit = wb_aw - 1;            // bit 11

  // total decoded words, both banks
  localparam int mem_words = n_banks << mem_aw;

endpackage

/* memory_sp.sv */
/*
  memory_sp
  Single-port synchronous RAM, behavioral.
  Registered read port, one write enable per byte lane.
  Lane count follows the data width.
*/

`timescale 1ns/1ps

module memory_sp #(
  parameter int aw = mem_pkg::mem_aw,  // word address width
  parameter int dw = mem_pkg::wb_dw    // data width, multiple of 8
) (
  input  logic            clk,
  input  logic            en,       // access enable, read and write
  input  logic [dw/8-1:0] wen,      // byte write enables
  input  logic [aw-1:0]   addr,     // word address
  input  logic [dw-1:0]   data_in,  // write data
  output logic [dw-1:0]   data_out  // read data, one cycle after en
);

  localparam int lanes = dw/8;     // byte lanes
  localparam int depth = 1 << aw;  // words

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  logic [dw-1:0] ram [depth];

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  // each lane writes its own byte at the shared address
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < lanes; i++) begin
        if (wen[i])
          ram[addr][i*8 +: 8] <= data_in[i*8 +: 8];
      end
    end
  end

  ////////////////////////////////////////
  // read port
  ////////////////////////////////////////

  // read before write on the same address
  // output holds while en is low
  always_ff @(posedge clk) begin
    if (en)
      data_out <= ram[addr];
  end

endmodule

/* wb_sram_port.sv */
/*
  wb_sram_port
  Wishbone classic slave adapter for one memory bank.
  Qualified strobe -> single ram access on the first cycle,
  byte enables from sel on writes, registered one-cycle ack.
*/

`timescale 1ns/1ps

module wb_sram_port (
  input  logic                      clk,
  input  logic                      rst_n,
  // wishbone classic slave side
  input  logic                      cyc,    // bus cycle active
  input  logic                      stb,    // bank strobe from decoder
  input  logic                      we,     // write when high
  input  logic [mem_pkg::mem_aw-1:0] adr,   // word address in bank
  input  logic [mem_pkg::sel_w-1:0] sel,    // byte selects
  input  logic [mem_pkg::wb_dw-1:0] dat_w,  // write data
  output logic [mem_pkg::wb_dw-1:0] dat_r,  // read data, valid with ack
  output logic                      ack     // one cycle after first strobe
);

  import mem_pkg::*;

  ////////////////////////////////////////
  // request qualification
  ////////////////////////////////////////

  logic             req;      // cyc and stb both up
  logic             ram_en;   // first strobe cycle only
  logic [sel_w-1:0] ram_wen;  // byte writes for this access

  assign req = cyc & stb;

  // ack high means the access is already done
  // master may still hold stb in the ack cycle
  assign ram_en = req & ~ack;

  // reads leave memory untouched
  assign ram_wen = we ? sel : '0;

  ////////////////////////////////////////
  // acknowledge
  ////////////////////////////////////////

  // set by the access edge, cleared at the next one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= ram_en;  // never two in a row
    end
  end

  ////////////////////////////////////////
  // bank storage
  ////////////////////////////////////////

  memory_sp #(
    .aw (mem_aw),
    .dw (wb_dw)
  ) u_ram (
    .clk      (clk),
    .en       (ram_en),
    .wen      (ram_wen),
    .addr     (adr),
    .data_in  (dat_w),
    .data_out (dat_r)   // registered read, lines up with ack
  );

endmodule

/* wb_bank_decode.sv */
/*
  wb_bank_decode
  Address decoder for the two-bank Wishbone memory.
  Steers the master strobe to one bank, answers out-of-range
  cycles with a one-cycle err, and returns the selected bank's data.
*/

`timescale 1ns/1ps

module wb_bank_decode (
  input  logic                                          clk,
  input  logic                                          rst_n,
  // master side
  input  logic                                          cyc,
  input  logic                                          stb,
  input  logic [mem_pkg::wb_aw-1:0]                     adr,
  output logic                                          ack,    // or of bank acks
  output logic                                          err,    // out-of-range reply
  output logic [mem_pkg::wb_dw-1:0]                     dat_r,
  // bank side
  output logic [mem_pkg::n_banks-1:0]                   bank_stb,
  input  logic [mem_pkg::n_banks-1:0]                   bank_ack,
  input  logic [mem_pkg::n_banks-1:0][mem_pkg::wb_dw-1:0] bank_dat_r
);

  import mem_pkg::*;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  logic                  req;       // cyc and stb both up
  logic                  in_range;  // range bit clear
  logic [bank_sel_w-1:0] bank_idx;  // bank picked by this address
  logic [bank_sel_w-1:0] bank_q;    // bank of the accepted cycle

  assign req      = cyc & stb;
  assign in_range = ~adr[range_bit];
  assign bank_idx = adr[mem_aw +: bank_sel_w];

  // one-hot strobe, nothing for out-of-range addresses
  always_comb begin
    bank_stb = '0;
    if (req && in_range)
      bank_stb[bank_idx] = 1'b1;
  end

  ////////////////////////////////////////
  // bank index and error
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bank_q <= '0;
      err    <= 1'b0;
    end else begin
      // held strobe in the ack cycle reloads the same bank
      if (req && in_range)
        bank_q <= bank_idx;
      // single cycle, even if stb is still up
      err <= req & ~in_range & ~err;
    end
  end

  ////////////////////////////////////////
  // response mux
  ////////////////////////////////////////

  assign ack   = |bank_ack;            // at most one bank answers
  assign dat_r = bank_dat_r[bank_q];   // data of the bank that was accepted

endmodule

/* mem_subsys_top.sv */
/*
  mem_subsys_top
  Wishbone classic memory slave, two byte-writable banks.
  Bank decoder in front of one port adapter and RAM per bank.
*/

`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // wishbone classic slave
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [mem_pkg::wb_aw-1:0] adr,    // word address
  input  logic [mem_pkg::sel_w-1:0] sel,
  input  logic [mem_pkg::wb_dw-1:0] dat_w,
  output logic [mem_pkg::wb_dw-1:0] dat_r,
  output logic                      ack,
  output logic                      err     // address above both banks
);

  import mem_pkg::*;

  ////////////////////////////////////////
  // decoder to bank wiring
  ////////////////////////////////////////

  logic [n_banks-1:0]            bank_stb;    // per-bank strobe
  logic [n_banks-1:0]            bank_ack;    // per-bank ack
  logic [n_banks-1:0][wb_dw-1:0] bank_dat_r;  // per-bank read data

  wb_bank_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .cyc        (cyc),
    .stb        (stb),
    .adr        (adr),
    .ack        (ack),
    .err        (err),
    .dat_r      (dat_r),
    .bank_stb   (bank_stb),
    .bank_ack   (bank_ack),
    .bank_dat_r (bank_dat_r)
  );

  ////////////////////////////////////////
  // banks
  ////////////////////////////////////////

  // shared cyc, we, sel, data; low address bits only
  for (genvar i = 0; i < n_banks; i++) begin : u_bank
    wb_sram_port u_port (
      .clk   (clk),
      .rst_n (rst_n),
      .cyc   (cyc),
      .stb   (bank_stb[i]),
      .we    (we),
      .adr   (adr[mem_aw-1:0]),
      .sel   (sel),
      .dat_w (dat_w),
      .dat_r (bank_dat_r[i]),
      .ack   (bank_ack[i])
    );
  end

endmodule

/* tb_ref_model.svh */
/*
  Testbench reference memory for the two-bank Wishbone slave.
  Word array over both banks, written-word tracking,
  byte merge and address-range helpers.
*/

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [wb_dw-1:0] ref_mem [mem_words];  // expected contents, both banks
bit               written [mem_words];  // word holds known data
int               written_list[$];      // indices of known words, read targets

// range bit clear -> one of the banks
function automatic bit addr_in_range(input logic [wb_aw-1:0] a);
  return a[range_bit] == 1'b0;
endfunction

// bank bit and word bits, range bit dropped
function automatic int model_index(input logic [wb_aw-1:0] a);
  return int'(a[range_bit-1:0]);
endfunction

// selected lanes from the new word, old bytes elsewhere
function automatic logic [wb_dw-1:0] byte_merge(input logic [wb_dw-1:0] old_w,
                                                input logic [wb_dw-1:0] new_w,
                                                input logic [sel_w-1:0] s);
  logic [wb_dw-1:0] r;
  r = old_w;
  for (int i = 0; i < sel_w; i++) begin
    if (s[i])
      r[i*8 +: 8] = new_w[i*8 +: 8];  // lane i replaced
  end
  return r;
endfunction

// out-of-range writes never reach memory
function automatic void model_write(input logic [wb_aw-1:0] a,
                                    input logic [sel_w-1:0] s,
                                    input logic [wb_dw-1:0] d);
  int idx;
  if (!addr_in_range(a))
    return;
  idx = model_index(a);
  ref_mem[idx] = byte_merge(ref_mem[idx], d, s);
  if (!written[idx]) begin
    written[idx] = 1'b1;
    written_list.push_back(idx);  // first write, now readable
  end
endfunction

`endif

/* tb_mem_subsys.sv */
/*
  tb_mem_subsys
  Testbench for the two-bank Wishbone classic memory slave.
  Directed and xorshift random bus cycles, checked against a
  reference memory, with response timing checks on every cycle.
*/

`timescale 1ns/1ps

module tb_mem_subsys;

  import mem_pkg::*;

  localparam int          n_rand     = 400;
  localparam int          n_directed = 16;                     // upper bound
  localparam int          wd_cycles  = (n_rand + n_directed) * 4 + 100;
  localparam int          resp_limit = 8;                      // cycles to wait for a reply
  localparam int          drive_dly  = 10;                     // ns after rising edge
  localparam logic [31:0] seed       = 32'd80;

  logic             clk;
  logic             rst_n;
  logic             cyc;
  logic             stb;
  logic             we;
  logic [wb_aw-1:0] adr;
  logic [sel_w-1:0] sel;
  logic [wb_dw-1:0] dat_w;
  logic [wb_dw-1:0] dat_r;
  logic             ack;
  logic             err;

  int          errors = 0;
  logic [31:0] rng_state = seed;

  `include "tb_ref_model.svh"

  mem_subsys_top u_mem_subsys (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .sel   (sel),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack),
    .err   (err)
  );

  ////////////////////////////////////////
  // clock, random source, checks
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  function automatic logic [31:0] xorshift();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // bus tasks entered at posedge + drive_dly
  ////////////////////////////////////////

  task automatic bus_cycle(input logic w, input logic [wb_aw-1:0] a,
                           input logic [sel_w-1:0] s, input logic [wb_dw-1:0] d,
                           output logic [wb_dw-1:0] q);
    int   waited;
    logic exp_err;
    exp_err = !addr_in_range(a);
    cyc     = 1'b1;
    stb     = 1'b1;
    we      = w;
    adr     = a;
    sel     = s;
    dat_w   = d;
    waited  = 0;
    do begin
      @(negedge clk);  // sample away from the edges
      waited++;
    end while (!ack && !err && waited < resp_limit);
    if (!ack && !err) begin
      errors++;
      $display("no ack or err seen for the cycle at address %h after %0d cycles", a, waited);
    end
    check($sformatf("reply delay at %h", a), waited, 2);  // one cycle after the strobe edge
    check($sformatf("ack at %h", a), ack, !exp_err);
    check($sformatf("err at %h", a), err, exp_err);
    q = dat_r;
    @(posedge clk);  // stb still held here
    #drive_dly;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    @(negedge clk);
    check("ack lasts one cycle", ack, 1'b0);
    check("err lasts one cycle", err, 1'b0);
    @(posedge clk);
    #drive_dly;
  endtask

  task automatic write_word(input logic [wb_aw-1:0] a, input logic [sel_w-1:0] s,
                            input logic [wb_dw-1:0] d);
    logic [wb_dw-1:0] q;
    bus_cycle(1'b1, a, s, d, q);
    model_write(a, s, d);
  endtask

  task automatic read_check(input logic [wb_aw-1:0] a);
    logic [wb_dw-1:0] q;
    bus_cycle(1'b0, a, '1, xorshift(), q);  // write data ignored on reads
    if (addr_in_range(a))
      check($sformatf("read data at %h", a), q, ref_mem[model_index(a)]);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #drive_dly;
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0]      r;
    logic [wb_aw-1:0] a;
    logic [wb_aw-1:0] a_oor;
    logic [sel_w-1:0] s;
    int               idx;
    rst_n = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    sel   = '0;
    dat_w = '0;
    repeat (2) @(posedge clk);
    #drive_dly;
    rst_n = 1'b1;
    @(negedge clk);
    check("ack after reset", ack, 1'b0);
    check("err after reset", err, 1'b0);
    @(posedge clk);
    #drive_dly;

    // two full words per bank
    for (int b = 0; b < n_banks; b++) begin
      for (int k = 0; k < 2; k++) begin
        a            = wb_aw'(xorshift());
        a[range_bit] = 1'b0;
        a[mem_aw]    = b[0];                  // bank bit
        write_word(a, '1, xorshift());
        read_check(a);
      end
    end

    // partial writes to the first and last known words
    // which sit in different banks
    for (int i = 0; i < 2; i++) begin
      idx = written_list[i * (written_list.size() - 1)];
      a   = wb_aw'(idx);
      do begin
        s = sel_w'(xorshift());
      end while (s == '0 || s == '1);         // some lanes kept and some replaced
      write_word(a, s, xorshift());
      read_check(a);
    end

    // out-of-range cycle on the low bits of a known word
    a            = wb_aw'(written_list[0]);
    a_oor        = a;
    a_oor[range_bit] = 1'b1;
    write_word(a_oor, '1, xorshift());
    read_check(a_oor);
    read_check(a);                            // model value unchanged

    // random mix
    for (int n = 0; n < n_rand; n++) begin
      r = xorshift();
      if (r[1:0] == 2'd0) begin
        a            = wb_aw'(xorshift());
        a[range_bit] = 1'b1;
        if (r[2])
          write_word(a, sel_w'(xorshift()), xorshift());
        else
          read_check(a);
      end else if (r[2] && written_list.size() > 0) begin
        idx = written_list[xorshift() % written_list.size()];
        read_check(wb_aw'(idx));
      end else begin
        a                 = wb_aw'(xorshift());
        a[range_bit]      = 1'b0;
        a[mem_aw-1:0]     = mem_aw'(xorshift() % 64);  // small window so words get rewritten
        // unknown words get a full write first
        s = written[model_index(a)] ? sel_w'(xorshift()) : '1;
        write_word(a, s, xorshift());
      end
      idle(int'(xorshift() % 2));             // 0 or 1 idle cycles
    end

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d clock cycles", wd_cycles);
    $display("errors: %0d", errors);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
mem_pkg.sv
memory_sp.sv
wb_sram_port.sv
wb_bank_decode.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

# two-bank Wishbone classic memory slave

sources:
  # design, package first
  - files:
      - mem_pkg.sv
      - memory_sp.sv
      - wb_sram_port.sv
      - wb_bank_decode.sv
      - mem_subsys_top.sv

  # testbench, includes tb_ref_model.svh from the root
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_subsys.sv
